// File: axi_block_mem.sv
/*
 * Single-beat AXI slave over MEM_DEPTH blocks, MEM_DEPTH a power of two from 2 up.
 * Byte addresses wrap modulo the depth; contents are undefined until written.
 * Read latency is two cycles from the AR handshake; B follows the W/AW pair.
 */

`default_nettype none

module axi_block_mem import mem_pkg::*; #(
    parameter int unsigned MEM_DEPTH = 256
) (
    input  logic    clk_i,
    input  logic    reset_i,
    axi_bus_if.slave axi
);

    localparam int unsigned IDX_W = $clog2(MEM_DEPTH);

    // Block index inside the array
    typedef logic [IDX_W-1:0] mem_idx_t;

    block_data_t mem [MEM_DEPTH];

    // Read engine state
    logic        ar_pend;
    mem_idx_t    ar_idx_q;
    req_id_t     ar_id_q;
    logic        r_valid_q;
    logic        r_free;
    req_id_t     r_id_q;
    block_data_t r_data_q;

    // Write engine state
    logic        aw_held;
    logic        w_held;
    mem_idx_t    aw_idx_q;
    req_id_t     aw_id_q;
    block_data_t w_data_q;
    block_mask_t w_strb_q;
    logic        b_valid_q;
    logic        wr_fire;

    // ##############################
    // Read engine
    // ##############################

    // R register empty or being drained this cycle
    assign r_free = !r_valid_q || axi.r_ready;

    // No new address while one waits or an R beat is stuck
    assign axi.ar_ready = !ar_pend && r_free;

    assign axi.r_valid = r_valid_q;
    assign axi.r_id    = r_id_q;
    assign axi.r_data  = r_data_q;
    assign axi.r_last  = 1'b1;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ar_pend   <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (axi.ar_valid && axi.ar_ready) begin
                ar_pend <= 1'b1;
            end else if (ar_pend && r_free) begin
                ar_pend <= 1'b0;
            end
            // Captured address moves into the R beat
            if (ar_pend && r_free) begin
                r_valid_q <= 1'b1;
            end else if (axi.r_valid && axi.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Address capture and array read
    always_ff @(posedge clk_i) begin
        if (axi.ar_valid && axi.ar_ready) begin
            ar_idx_q <= axi.ar_addr[ADDR_SHIFT +: IDX_W];
            ar_id_q  <= axi.ar_id;
        end
        if (ar_pend && r_free) begin
            r_data_q <= mem[ar_idx_q];
            r_id_q   <= ar_id_q;
        end
    end

    // ##############################
    // Write engine
    // ##############################

    // Each channel stalls while its beat is held
    assign axi.aw_ready = !aw_held;
    assign axi.w_ready  = !w_held;

    // Both halves present and B not yet raised
    assign wr_fire = aw_held && w_held && !b_valid_q;

    assign axi.b_valid = b_valid_q;
    // AW stays held until B goes, so the id is stable
    assign axi.b_id    = aw_id_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            b_valid_q <= 1'b0;
        end else if (axi.b_valid && axi.b_ready) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (axi.aw_valid && axi.aw_ready) begin
                aw_held <= 1'b1;
            end
            // Beat closes the write only when marked last
            if (axi.w_valid && axi.w_ready) begin
                w_held <= axi.w_last;
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end
        end
    end

    // Holding registers and strobed array write
    always_ff @(posedge clk_i) begin
        if (axi.aw_valid && axi.aw_ready) begin
            aw_idx_q <= axi.aw_addr[ADDR_SHIFT +: IDX_W];
            aw_id_q  <= axi.aw_id;
        end
        if (axi.w_valid && axi.w_ready) begin
            w_data_q <= axi.w_data;
            w_strb_q <= axi.w_strb;
        end
        if (wr_fire) begin
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                if (w_strb_q[b]) begin
                    mem[aw_idx_q][8*b +: 8] <= w_data_q[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: axi_bus_if.sv
/*
 * Reduced AXI bus: single-beat transfers, no size, burst, prot, cache or resp.
 * Valid stays high with a stable payload until the valid/ready handshake.
 */

`default_nettype none

interface axi_bus_if import mem_pkg::*; ();

    // Read address channel
    logic      ar_valid;
    logic      ar_ready;
    axi_addr_t ar_addr;
    req_id_t   ar_id;

    // Write address channel
    logic      aw_valid;
    logic      aw_ready;
    axi_addr_t aw_addr;
    req_id_t   aw_id;

    // Write data channel
    logic        w_valid;
    logic        w_ready;
    block_data_t w_data;
    block_mask_t w_strb;
    logic        w_last;

    // Write response channel
    logic    b_valid;
    logic    b_ready;
    req_id_t b_id;

    // Read data channel
    logic        r_valid;
    logic        r_ready;
    req_id_t     r_id;
    block_data_t r_data;
    logic        r_last;

    // Adapter side
    modport master (
        output ar_valid, ar_addr, ar_id, input ar_ready,
        output aw_valid, aw_addr, aw_id, input aw_ready,
        output w_valid, w_data, w_strb, w_last, input w_ready,
        input b_valid, b_id, output b_ready,
        input r_valid, r_id, r_data, r_last, output r_ready
    );

    // Memory side
    modport slave (
        input ar_valid, ar_addr, ar_id, output ar_ready,
        input aw_valid, aw_addr, aw_id, output aw_ready,
        input w_valid, w_data, w_strb, w_last, output w_ready,
        output b_valid, b_id, input b_ready,
        output r_valid, r_id, r_data, r_last, input r_ready
    );

endinterface

`default_nettype wire

// File: mem_pkg.sv
/*
 * Widths and types shared by the adapter, the AXI bus and the memory.
 * A block is BLOCK_BYTES bytes wide and AXI addresses are byte addresses.
 * The memory depth is not set here; it is a parameter of the top level.
 */

`default_nettype none

package mem_pkg;

    // ##############################
    // Block geometry
    // ##############################

    // Bytes in one data block
    localparam int unsigned BLOCK_BYTES = 8;

    // Shift from block index to byte address
    localparam int unsigned ADDR_SHIFT = $clog2(BLOCK_BYTES);

    // ##############################
    // Payload types
    // ##############################

    // Request id, echoed back in the response
    typedef logic [3:0] req_id_t;

    // Block index as issued by the compute unit
    typedef logic [15:0] block_addr_t;

    // AXI byte address
    typedef logic [31:0] axi_addr_t;

    // Byte enables, one bit per byte of a block
    typedef logic [BLOCK_BYTES-1:0] block_mask_t;

    // One full data block
    typedef logic [8*BLOCK_BYTES-1:0] block_data_t;

endpackage

`default_nettype wire

// File: mem_req_split.sv
/*
 * Request splitter: a zero mask is a read on AR, any other mask a write on AW and W.
 * The request payload must stay stable while req_valid_i is high and not accepted.
 */

`default_nettype none

module mem_req_split import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  req_id_t     req_id_i,
    input  block_addr_t req_addr_i,
    input  block_mask_t req_mask_i,
    input  block_data_t req_wdata_i,
    axi_bus_if.master   axi
);

    // Any enabled byte makes it a write
    logic      is_write;
    axi_addr_t byte_addr;

    // Beats already handed over for the current write
    logic aw_sent;
    logic w_sent;
    logic aw_done;
    logic w_done;
    logic wr_accept;

    assign is_write  = |req_mask_i;
    assign byte_addr = axi_addr_t'(req_addr_i) << ADDR_SHIFT;

    // ##############################
    // Read path, purely combinational
    // ##############################

    assign axi.ar_valid = req_valid_i && !is_write;
    assign axi.ar_addr  = byte_addr;
    assign axi.ar_id    = req_id_i;

    // ##############################
    // Write path, AW and W forked
    // ##############################

    assign axi.aw_valid = req_valid_i && is_write && !aw_sent;
    assign axi.aw_addr  = byte_addr;
    assign axi.aw_id    = req_id_i;

    assign axi.w_valid = req_valid_i && is_write && !w_sent;
    assign axi.w_data  = req_wdata_i;
    assign axi.w_strb  = req_mask_i;
    // Single-beat writes only
    assign axi.w_last  = 1'b1;

    // A beat counts as done once sent earlier or in this cycle
    assign aw_done   = aw_sent || (axi.aw_valid && axi.aw_ready);
    assign w_done    = w_sent || (axi.w_valid && axi.w_ready);
    assign wr_accept = req_valid_i && is_write && aw_done && w_done;

    // Write retires only when both beats have gone out
    assign req_ready_o = is_write ? (aw_done && w_done) : axi.ar_ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else if (wr_accept) begin
            // Request retired, arm the fork for the next write
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (axi.aw_valid && axi.aw_ready) begin
                aw_sent <= 1'b1;
            end
            if (axi.w_valid && axi.w_ready) begin
                w_sent <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_rsp_arbiter.sv
/*
 * Round-robin merge of R and B into one response stream.
 * The consumer has no ready; a granted beat is always taken in the same cycle.
 */

`default_nettype none

module mem_rsp_arbiter import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    axi_bus_if.master   axi,
    output logic        rsp_valid_o,
    output req_id_t     rsp_id_o,
    output block_data_t rsp_data_o
);

    // High while R is favoured on a tie
    logic prio_r;
    logic grant_r;
    logic grant_b;

    // ##############################
    // Grant
    // ##############################

    // The favoured side wins a tie, a lone request always wins
    assign grant_r = axi.r_valid && (!axi.b_valid || prio_r);
    assign grant_b = axi.b_valid && (!axi.r_valid || !prio_r);

    // Granted beat is consumed at once
    assign axi.r_ready = grant_r;
    assign axi.b_ready = grant_b;

    // ##############################
    // Response mux
    // ##############################

    // Read response is complete on the last R beat
    assign rsp_valid_o = (grant_r && axi.r_last) || grant_b;
    assign rsp_id_o    = grant_b ? axi.b_id : axi.r_id;
    // Writes return no data
    assign rsp_data_o  = grant_b ? '0 : axi.r_data;

    // Favour flips to the other side after every grant
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prio_r <= 1'b1;
        end else if (grant_r) begin
            prio_r <= 1'b0;
        end else if (grant_b) begin
            prio_r <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mem_subsystem.sv
/*
 * Compute-unit memory port backed by an AXI block memory of MEM_DEPTH blocks.
 * Uncontended reads answer two cycles after acceptance; write latency varies.
 */

`default_nettype none

module mem_subsystem import mem_pkg::*; #(
    parameter int unsigned MEM_DEPTH = 256
) (
    input  logic        clk_i,
    input  logic        reset_i,

    // Request port
    output logic        mem_ready_o,
    input  logic        mem_req_valid_i,
    input  req_id_t     mem_req_id_i,
    input  block_addr_t mem_req_addr_i,
    input  block_mask_t mem_req_we_mask_i,
    input  block_data_t mem_req_wdata_i,

    // Response port
    output logic        mem_rsp_valid_o,
    output req_id_t     mem_rsp_id_o,
    output block_data_t mem_rsp_data_o
);

    // Internal AXI link
    axi_bus_if u_axi ();

    // ##############################
    // Adapter and memory
    // ##############################

    mem_to_axi u_adapter (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .mem_ready_o       (mem_ready_o),
        .mem_req_valid_i   (mem_req_valid_i),
        .mem_req_id_i      (mem_req_id_i),
        .mem_req_addr_i    (mem_req_addr_i),
        .mem_req_we_mask_i (mem_req_we_mask_i),
        .mem_req_wdata_i   (mem_req_wdata_i),
        .mem_rsp_valid_o   (mem_rsp_valid_o),
        .mem_rsp_id_o      (mem_rsp_id_o),
        .mem_rsp_data_o    (mem_rsp_data_o),
        .axi               (u_axi.master)
    );

    axi_block_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .axi     (u_axi.slave)
    );

endmodule

`default_nettype wire

// File: mem_to_axi.sv
/*
 * Compute-unit block memory port to AXI master.
 * Reads and writes may be outstanding together; their responses may reorder.
 * Responses come as one-cycle pulses with no back-pressure.
 */

`default_nettype none

module mem_to_axi import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,

    // Requests from the compute unit
    output logic        mem_ready_o,
    input  logic        mem_req_valid_i,
    input  req_id_t     mem_req_id_i,
    input  block_addr_t mem_req_addr_i,
    input  block_mask_t mem_req_we_mask_i,
    input  block_data_t mem_req_wdata_i,

    // Responses to the compute unit
    output logic        mem_rsp_valid_o,
    output req_id_t     mem_rsp_id_o,
    output block_data_t mem_rsp_data_o,

    // Bus towards the memory
    axi_bus_if.master   axi
);

    // ##############################
    // Request path
    // ##############################

    // Drives AR, AW and W
    mem_req_split u_req_split (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (mem_req_valid_i),
        .req_ready_o (mem_ready_o),
        .req_id_i    (mem_req_id_i),
        .req_addr_i  (mem_req_addr_i),
        .req_mask_i  (mem_req_we_mask_i),
        .req_wdata_i (mem_req_wdata_i),
        .axi         (axi)
    );

    // ##############################
    // Response path
    // ##############################

    // Drives r_ready and b_ready
    mem_rsp_arbiter u_rsp_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .axi         (axi),
        .rsp_valid_o (mem_rsp_valid_o),
        .rsp_id_o    (mem_rsp_id_o),
        .rsp_data_o  (mem_rsp_data_o)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
# Exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_mem_subsystem -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_mem_subsystem.sv
/*
 * Testbench for mem_subsystem at MEM_DEPTH 256, checked against a shadow block array.
 * Blocks are valid in the shadow only after test 1 has written blocks 0 to 15.
 */

`default_nettype none

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int unsigned MEM_DEPTH   = 256;
    localparam int unsigned TOTAL_REQS  = 16 + 16 + 16 + 200 + 2;
    localparam int unsigned WD_CYCLES   = TOTAL_REQS * 20 + 10 + 200;
    localparam int          MAX_PENDING = 8;

    logic        clk_i;
    logic        reset_i;
    logic        mem_ready_o;
    logic        mem_req_valid_i;
    req_id_t     mem_req_id_i;
    block_addr_t mem_req_addr_i;
    block_mask_t mem_req_we_mask_i;
    block_data_t mem_req_wdata_i;
    logic        mem_rsp_valid_o;
    req_id_t     mem_rsp_id_o;
    block_data_t mem_rsp_data_o;

    // Reference state and the table of outstanding ids
    block_data_t shadow [MEM_DEPTH];
    int          blk_busy [MEM_DEPTH];
    logic        pending [16];
    block_data_t exp_data [16];
    int unsigned exp_blk [16];
    int          issue_cyc [16];
    int          rsp_lat [16];
    int          outstanding;
    int          cycle_cnt;
    int          err_cnt;
    int          err_base;
    int          check_cnt;
    int          tests_run;
    int          tests_failed;
    string       cur_test;

    mem_subsystem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_dut (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .mem_ready_o       (mem_ready_o),
        .mem_req_valid_i   (mem_req_valid_i),
        .mem_req_id_i      (mem_req_id_i),
        .mem_req_addr_i    (mem_req_addr_i),
        .mem_req_we_mask_i (mem_req_we_mask_i),
        .mem_req_wdata_i   (mem_req_wdata_i),
        .mem_rsp_valid_o   (mem_rsp_valid_o),
        .mem_rsp_id_o      (mem_rsp_id_o),
        .mem_rsp_data_o    (mem_rsp_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ##############################
    // Reference model
    // ##############################

    // Byte-wise merge of write data into a stored block
    function automatic block_data_t merge_block(block_data_t old, block_data_t wdata,
                                                block_mask_t mask);
        block_data_t res;
        res = old;
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Writes answer with zero data, reads with the stored block
    function automatic block_data_t expected_rsp_data(block_mask_t mask, block_data_t stored);
        return (mask == '0) ? stored : '0;
    endfunction

    // ##############################
    // Stimulus
    // ##############################

    // Starts 2 units after a rising edge and returns at the same phase
    task automatic send_req(input req_id_t id, input block_addr_t addr,
                            input block_mask_t mask, input block_data_t wdata);
        int unsigned idx;
        logic        ready_seen;
        idx = {16'd0, addr} % MEM_DEPTH;
        if (mask != '0) begin
            shadow[idx] = merge_block(shadow[idx], wdata, mask);
        end
        exp_data[id] = expected_rsp_data(mask, shadow[idx]);
        exp_blk[id]  = idx;
        pending[id]  = 1'b1;
        blk_busy[idx]++;
        outstanding++;
        mem_req_valid_i   = 1'b1;
        mem_req_id_i      = id;
        mem_req_addr_i    = addr;
        mem_req_we_mask_i = mask;
        mem_req_wdata_i   = wdata;
        ready_seen = 1'b0;
        // Ready sampled mid-cycle and the transfer made on the following edge
        while (!ready_seen) begin
            @(negedge clk_i);
            ready_seen = mem_ready_o;
            issue_cyc[id] = cycle_cnt;
            @(posedge clk_i);
        end
        #2;
        mem_req_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0) begin
            @(posedge clk_i);
            #2;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = err_cnt;
    endtask

    task automatic end_test();
        string verdict;
        drain();
        tests_run++;
        if (err_cnt != err_base) begin
            tests_failed++;
            verdict = "failed";
        end else begin
            verdict = "ok";
        end
        $display("%s: %s, %0d errors", cur_test, verdict, err_cnt - err_base);
    endtask

    // ##############################
    // Response monitor
    // ##############################

    task automatic check_response();
        req_id_t rid;
        rid = mem_rsp_id_o;
        assert (pending[rid]) else begin
            $display("%s: response with id %0d arrived with no such request outstanding",
                     cur_test, rid);
            err_cnt++;
        end
        if (pending[rid]) begin
            check_cnt++;
            assert (mem_rsp_data_o === exp_data[rid]) else begin
                $display("FAILED %s id %0d: expected %h, actual %h", cur_test, rid,
                         exp_data[rid], mem_rsp_data_o);
                err_cnt++;
            end
            rsp_lat[rid] = cycle_cnt - issue_cyc[rid];
            pending[rid] = 1'b0;
            blk_busy[exp_blk[rid]]--;
            outstanding--;
        end
    endtask

    // Pulses last one cycle, so each is seen at exactly one falling edge
    always @(negedge clk_i) begin
        if (!reset_i && mem_rsp_valid_o) begin
            check_response();
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Timeout: %0d responses still missing in %s", outstanding, cur_test);
        $display("Testbench failed");
        $finish;
    end

    // ##############################
    // Test sequence
    // ##############################

    initial begin
        logic [31:0] rnd;
        block_mask_t mask;
        req_id_t     next_id;
        int          blk;
        void'($urandom(32'ha9c961d4));
        reset_i           = 1'b1;
        mem_req_valid_i   = 1'b0;
        mem_req_id_i      = '0;
        mem_req_addr_i    = '0;
        mem_req_we_mask_i = '0;
        mem_req_wdata_i   = '0;
        outstanding  = 0;
        err_cnt      = 0;
        check_cnt    = 0;
        tests_run    = 0;
        tests_failed = 0;
        next_id      = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i]   = 'x;
            blk_busy[i] = 0;
        end
        for (int i = 0; i < 16; i++) begin
            pending[i] = 1'b0;
        end
        repeat (10) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // Idle bus followed by full writes of blocks 0 to 15
        start_test("test 1 idle and full writes");
        repeat (8) begin
            @(negedge clk_i);
            assert (!mem_rsp_valid_o) else begin
                $display("%s: response valid raised with no request sent", cur_test);
                err_cnt++;
            end
        end
        @(posedge clk_i);
        #2;
        for (int i = 0; i < 16; i++) begin
            send_req(req_id_t'(i), block_addr_t'(i), 8'hff, {$urandom(), $urandom()});
            drain();
        end
        end_test();

        // Uncontended reads with fixed latency
        start_test("test 2 read back");
        for (int i = 0; i < 16; i++) begin
            send_req(req_id_t'(i), block_addr_t'(i), '0, '0);
            drain();
            assert (rsp_lat[i] == 2) else begin
                $display("FAILED %s latency id %0d: expected 2, actual %0d", cur_test, i,
                         rsp_lat[i]);
                err_cnt++;
            end
        end
        end_test();

        start_test("test 3 partial writes");
        for (int i = 0; i < 8; i++) begin
            rnd  = $urandom();
            mask = (rnd[7:0] == '0) ? 8'h01 : rnd[7:0];
            send_req(req_id_t'(i), block_addr_t'(2 * i), mask, {$urandom(), $urandom()});
        end
        drain();
        for (int i = 0; i < 8; i++) begin
            send_req(req_id_t'(i + 8), block_addr_t'(2 * i), '0, '0);
        end
        end_test();

        // Back to back mix that touches only idle blocks
        start_test("test 4 random stream");
        for (int n = 0; n < 200; n++) begin
            while (outstanding >= MAX_PENDING) begin
                @(posedge clk_i);
                #2;
            end
            while (pending[next_id]) begin
                next_id++;
            end
            do begin
                blk = $urandom_range(15, 0);
            end while (blk_busy[blk] != 0);
            rnd  = $urandom();
            mask = rnd[31] ? '0 : rnd[7:0];
            send_req(next_id, block_addr_t'(blk), mask, {$urandom(), $urandom()});
            next_id++;
        end
        end_test();

        start_test("test 5 address wrap");
        send_req(4'd1, block_addr_t'(MEM_DEPTH + 5), 8'hff, {$urandom(), $urandom()});
        drain();
        send_req(4'd2, block_addr_t'(5), '0, '0);
        end_test();

        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d", tests_run,
                 tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
mem_pkg.sv
axi_bus_if.sv
mem_req_split.sv
mem_rsp_arbiter.sv
mem_to_axi.sv
axi_block_mem.sv
mem_subsystem.sv
tb_mem_subsystem.sv
